// ==== Makefile ====
# Verilator build and run for the audio band filter

VERILATOR ?= verilator
TOP       ?= audio_band_filter_tb
FILELIST  ?= audio_band_filter.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== audio_band_filter.f ====
+incdir+.
bpf_pkg.sv
sample_rx.sv
band_coef_rom.sv
iir_bandpass.sv
envelope_lpf.sv
sample_tx.sv
audio_band_filter.sv
audio_band_filter_assert.sv
audio_band_filter_tb.sv

// ==== audio_band_filter.sv ====
`default_nettype none

module audio_band_filter (
  input  logic                    aud_clk,
  input  logic                    reset,
  input  logic                    enable,
  input  bpf_pkg::band_e          band_sel,
  input  logic                    in_valid,
  input  bpf_pkg::stereo_sample_t in_sample,
  output logic                    in_credit,
  output logic                    out_valid,
  output bpf_pkg::band_result_t   out_result,
  input  logic                    out_credit
);
  import bpf_pkg::*;

  stereo_sample_t rx_sample;
  stereo_sample_t filt_sample;
  band_result_t   env_result;
  coef_set_t      coefs;
  logic           rx_valid;
  logic           rx_pop;
  logic           tx_room;
  logic           filt_valid;
  logic           filt_enabled;
  logic           env_valid;

  sample_rx rx_i (
    .aud_clk   (aud_clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_sample (in_sample),
    .in_credit (in_credit),
    .rx_valid  (rx_valid),
    .rx_sample (rx_sample),
    .rx_pop    (rx_pop)
  );

  band_coef_rom rom_i (
    .aud_clk  (aud_clk),
    .band_sel (band_sel),
    .coefs    (coefs)
  );

  iir_bandpass iir_i (
    .aud_clk      (aud_clk),
    .reset        (reset),
    .enable       (enable),
    .coefs        (coefs),
    .rx_valid     (rx_valid),
    .rx_sample    (rx_sample),
    .rx_pop       (rx_pop),
    .tx_room      (tx_room),
    .filt_valid   (filt_valid),
    .filt_sample  (filt_sample),
    .filt_enabled (filt_enabled)
  );

  envelope_lpf env_i (
    .aud_clk      (aud_clk),
    .reset        (reset),
    .filt_valid   (filt_valid),
    .filt_sample  (filt_sample),
    .filt_enabled (filt_enabled),
    .env_valid    (env_valid),
    .env_result   (env_result)
  );

  sample_tx tx_i (
    .aud_clk    (aud_clk),
    .reset      (reset),
    .env_valid  (env_valid),
    .env_result (env_result),
    .tx_room    (tx_room),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

endmodule

`default_nettype wire

// ==== audio_band_filter_assert.sv ====
`default_nettype none
`include "bpf_macros.svh"

module audio_band_filter_assert (
  input logic aud_clk,
  input logic reset,
  input logic in_credit,
  input logic out_valid,
  input logic out_credit
);
  timeunit 1ns;
  timeprecision 1ps;

  int credits;

  // Mirror of the downstream credit counter
  always_ff @(posedge aud_clk) begin
    if (reset) begin
      credits <= `FIFO_DEPTH;
    end else begin
      credits <= credits - int'(out_valid) + int'(out_credit);
    end
  end

  a_credit_held: assert property (
    @(posedge aud_clk) disable iff (reset) out_valid |-> credits > 0
  ) else $error("out_valid with no downstream credit");

  a_credit_pulse: assert property (
    @(posedge aud_clk) disable iff (reset) in_credit |=> !in_credit
  ) else $error("in_credit held longer than one cycle");

  a_quiet_after_reset: assert property (
    @(posedge aud_clk) reset |=> (!in_credit && !out_valid)
  ) else $error("control output high right after reset");

endmodule

`default_nettype wire

// ==== audio_band_filter_tb.sv ====
`default_nettype none
`include "bpf_macros.svh"

module audio_band_filter_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import bpf_pkg::*;

  localparam int WAIT_LIMIT = 3000;

  logic           aud_clk;
  logic           reset;
  logic           enable;
  band_e          band_sel;
  logic           in_valid;
  stereo_sample_t in_sample;
  logic           in_credit;
  logic           out_valid;
  band_result_t   out_result;
  logic           out_credit = 1'b0;

  band_result_t   exp_q [$];
  string          test_name = "startup";
  int             check_count = 0;
  int             mismatch_count = 0;
  int             fault_count = 0;
  int             sent = 0;
  int             credits_back = 0;
  int             pop_count = 0;
  int             rcv_count = 0;
  int             owed = 0;
  int             hold_left = 0;
  logic           bp_mode = 1'b0;
  logic           en_model = 1'b0;
  longint         z [2][4];
  longint         acc;
  longint         cb1, cb3, cb5, ca2, ca3, ca4, ca5;

  audio_band_filter dut_i (
    .aud_clk    (aud_clk),
    .reset      (reset),
    .enable     (enable),
    .band_sel   (band_sel),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

  bind audio_band_filter audio_band_filter_assert assert_i (
    .aud_clk    (aud_clk),
    .reset      (reset),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
  );

  initial begin
    aud_clk = 1'b0;
    forever #50 aud_clk = ~aud_clk;
  end

  task automatic check_val(input string name, input int expected, input int actual);
    check_count++;
    if (expected !== actual) begin
      mismatch_count++;
      $display("Error %s %s: expected %0d, actual %0d", test_name, name, expected, actual);
    end
  endtask

  task automatic report_fault(input string msg);
    fault_count++;
    $display("Failure in %s: %s", test_name, msg);
  endtask

  // Reference coefficient table, one row per band
  function automatic coef_set_t band_coefs(input band_e band);
    coef_set_t c;
    case (band)
      BAND_10_100: c = '{
        b1: 27'h0_000003, b3: 27'h7_FFFFF9, b5: 27'h0_000003, a2: 27'h6_003CBF,
        a3: 27'h3_FF49E8, a4: 27'h6_00B5F4, a5: 27'h0_7FC365};
      BAND_100_500: c = '{
        b1: 27'h0_000020, b3: 27'h7_FFFFC0, b5: 27'h0_000020, a2: 27'h6_00B6BD,
        a3: 27'h3_FDDD0D, a4: 27'h6_0221B0, a5: 27'h0_7F4A86};
      BAND_500_1K: c = '{
        b1: 27'h0_000120, b3: 27'h7_FFFDBF, b5: 27'h0_000120, a2: 27'h6_0228B9,
        a3: 27'h3_F99131, a4: 27'h6_066381, a5: 27'h0_7DE294};
      BAND_1K_5K: c = '{
        b1: 27'h0_0009FB, b3: 27'h7_FFEC0A, b5: 27'h0_0009FB, a2: 27'h6_06A221,
        a3: 27'h3_EC7FB4, a4: 27'h6_131BC4, a5: 27'h0_79C26E};
      BAND_5K_10K: c = '{
        b1: 27'h0_00559A, b3: 27'h7_FF54CC, b5: 27'h0_00559A, a2: 27'h6_153D41,
        a3: 27'h3_C3DB52, a4: 27'h6_38BC6A, a5: 27'h0_6E2D2D};
      BAND_10K_20K: c = '{
        b1: 27'h0_02A10C, b3: 27'h7_FABDE7, b5: 27'h0_02A10C, a2: 27'h6_4A2ECD,
        a3: 27'h2_4163D1, a4: 27'h6_A3611C, a5: 27'h0_51A391};
      BAND_WIDE: c = '{
        b1: 27'h0_111E4F, b3: 27'h7_DDC361, b5: 27'h0_111E4F, a2: 27'h7_1C4478,
        a3: 27'h0_CA6B97, a4: 27'h7_963176, a5: 27'h0_22578B};
      default: c = '0;
    endcase
    return c;
  endfunction

  // Keep the low filter-word bits, sign-extended
  function automatic longint to_word(input longint v);
    logic signed [`COEF_W-1:0] t;
    t = v[`COEF_W-1:0];
    return longint'(t);
  endfunction

  function automatic longint qmul(input longint a, input longint b);
    return to_word((a * b) >>> `FRAC_W);
  endfunction

  function automatic logic [`AUD_W-1:0] filter_channel(input int c, input longint s);
    longint x;
    longint y;
    x = s * 256;
    y = to_word(qmul(x, cb1) + z[c][0]);
    z[c][0] = to_word(z[c][1] - qmul(y, ca2));
    z[c][1] = to_word(qmul(x, cb3) + z[c][2] - qmul(y, ca3));
    z[c][2] = to_word(z[c][3] - qmul(y, ca4));
    z[c][3] = to_word(qmul(x, cb5) - qmul(y, ca5));
    return y[24:9];
  endfunction

  function automatic logic [`POWER_W-1:0] envelope_power(input logic signed [`AUD_W-1:0] l);
    longint w;
    longint mag;
    longint diff;
    w    = longint'(l) * 512;
    mag  = (w < 0) ? -w : w;
    diff = to_word(mag - acc);
    acc  = to_word(acc + (diff >>> `LPF_SHIFT));
    return acc[23:13];
  endfunction

  function automatic void model_sample(input stereo_sample_t s);
    band_result_t e;
    if (en_model) begin
      e.l     = filter_channel(0, longint'(s.l));
      e.r     = filter_channel(1, longint'(s.r));
      e.power = envelope_power(e.l);
    end else begin
      e.l     = s.l;
      e.r     = s.r;
      e.power = '0;
    end
    exp_q.push_back(e);
  endfunction

  // Credit and pop counters, updated after the edge
  always @(posedge aud_clk) begin
    if (reset) begin
      credits_back <= 0;
      pop_count    <= 0;
    end else begin
      if (in_credit) begin
        credits_back <= credits_back + 1;
      end
      if (dut_i.rx_pop) begin
        pop_count <= pop_count + 1;
      end
    end
  end

  // Sink returns credits late, with long stalls in back-pressure mode
  always @(posedge aud_clk) begin
    if (reset) begin
      owed = 0;
      hold_left = 0;
      out_credit <= 1'b0;
    end else begin
      if (out_valid) begin
        owed++;
      end
      if (hold_left > 0) begin
        hold_left--;
      end else if (bp_mode && $urandom_range(0, 19) == 0) begin
        hold_left = $urandom_range(30, 80);
      end
      if (hold_left == 0 && owed > 0 && $urandom_range(0, 2) == 0) begin
        out_credit <= 1'b1;
        owed--;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  always @(posedge aud_clk) begin
    band_result_t e;
    if (reset) begin
      rcv_count <= 0;
    end else if (out_valid) begin
      rcv_count <= rcv_count + 1;
      if (exp_q.size() == 0) begin
        report_fault("an output arrived with no sample outstanding");
      end else begin
        e = exp_q.pop_front();
        check_val("l", int'(e.l), int'(out_result.l));
        check_val("r", int'(e.r), int'(out_result.r));
        check_val("power", int'(e.power), int'(out_result.power));
      end
    end
  end

  task automatic set_enable(input logic v);
    enable <= v;
    en_model = v;
  endtask

  task automatic apply_reset(input band_e band);
    coef_set_t c;
    @(posedge aud_clk);
    band_sel <= band;
    reset    <= 1'b1;
    in_valid <= 1'b0;
    repeat (2) @(posedge aud_clk);
    reset <= 1'b0;
    @(posedge aud_clk);
    sent = 0;
    acc  = 0;
    exp_q.delete();
    for (int ch = 0; ch < 2; ch++) begin
      for (int k = 0; k < 4; k++) begin
        z[ch][k] = 0;
      end
    end
    c   = band_coefs(band);
    cb1 = longint'(c.b1);
    cb3 = longint'(c.b3);
    cb5 = longint'(c.b5);
    ca2 = longint'(c.a2);
    ca3 = longint'(c.a3);
    ca4 = longint'(c.a4);
    ca5 = longint'(c.a5);
  endtask

  task automatic send_samples(input int n);
    int             done;
    int             waited;
    int             avail;
    stereo_sample_t s;
    done   = 0;
    waited = 0;
    while (done < n && waited < WAIT_LIMIT) begin
      @(posedge aud_clk);
      avail = `FIFO_DEPTH - sent + credits_back;
      check_val("source_credits", 1, int'(avail >= 0 && avail <= `FIFO_DEPTH));
      if (avail > 0 && $urandom_range(0, 3) != 0) begin
        s = stereo_sample_t'($urandom);
        in_valid  <= 1'b1;
        in_sample <= s;
        model_sample(s);
        sent++;
        done++;
        waited = 0;
      end else begin
        in_valid <= 1'b0;
        if (avail == 0) begin
          waited++;
        end
      end
    end
    @(posedge aud_clk);
    in_valid <= 1'b0;
    if (done < n) begin
      report_fault("the source waited too long for a credit");
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (!(rcv_count == sent && credits_back == sent && pop_count == sent)
           && waited < WAIT_LIMIT) begin
      @(posedge aud_clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      report_fault("the outputs or credits did not all come back");
    end
    check_val("credits_back", `FIFO_DEPTH, `FIFO_DEPTH - sent + credits_back);
    check_val("credit_pulses", pop_count, credits_back);
    check_val("outputs", sent, rcv_count);
    check_val("left_over", 0, exp_q.size());
  endtask

  initial begin
    void'($urandom(32'h30a87d87));
    reset     = 1'b1;
    enable    = 1'b0;
    band_sel  = BAND_1K_5K;
    in_valid  = 1'b0;
    in_sample = '0;

    test_name = "filter_1k_5k";
    set_enable(1'b1);
    apply_reset(BAND_1K_5K);
    send_samples(200);
    drain();

    test_name = "band_sweep";
    for (int b = 0; b < 7; b++) begin
      apply_reset(band_e'(b));
      send_samples(40);
      drain();
    end

    // Build up filter state, bypass, then resume from it
    test_name = "bypass";
    apply_reset(BAND_500_1K);
    send_samples(20);
    drain();
    set_enable(1'b0);
    send_samples(30);
    drain();
    set_enable(1'b1);
    send_samples(30);
    drain();

    test_name = "back_pressure";
    bp_mode <= 1'b1;
    send_samples(80);
    bp_mode <= 1'b0;
    drain();

    $display("Checks: %0d, mismatches: %0d, other failures: %0d",
             check_count, mismatch_count, fault_count);
    if (mismatch_count == 0 && fault_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== band_coef_rom.sv ====
`default_nettype none

module band_coef_rom (
  input  logic               aud_clk,
  input  bpf_pkg::band_e     band_sel,
  output bpf_pkg::coef_set_t coefs
);
  import bpf_pkg::*;

  coef_set_t row;

  // Generated filter table, one row per band
  always_comb begin
    case (band_sel)
      BAND_10_100: row = '{
        b1: 27'b000_0000_0000_0000_0000_0000_0011, b3: 27'b111_1111_1111_1111_1111_1111_1001,
        b5: 27'b000_0000_0000_0000_0000_0000_0011, a2: 27'b110_0000_0000_0011_1100_1011_1111,
        a3: 27'b011_1111_1111_0100_1001_1110_1000, a4: 27'b110_0000_0000_1011_0101_1111_0100,
        a5: 27'b000_0111_1111_1100_0011_0110_0101};
      BAND_100_500: row = '{
        b1: 27'b000_0000_0000_0000_0000_0010_0000, b3: 27'b111_1111_1111_1111_1111_1100_0000,
        b5: 27'b000_0000_0000_0000_0000_0010_0000, a2: 27'b110_0000_0000_1011_0110_1011_1101,
        a3: 27'b011_1111_1101_1101_1101_0000_1101, a4: 27'b110_0000_0010_0010_0001_1011_0000,
        a5: 27'b000_0111_1111_0100_1010_1000_0110};
      BAND_500_1K: row = '{
        b1: 27'b000_0000_0000_0000_0001_0010_0000, b3: 27'b111_1111_1111_1111_1101_1011_1111,
        b5: 27'b000_0000_0000_0000_0001_0010_0000, a2: 27'b110_0000_0010_0010_1000_1011_1001,
        a3: 27'b011_1111_1001_1001_0001_0011_0001, a4: 27'b110_0000_0110_0110_0011_1000_0001,
        a5: 27'b000_0111_1101_1110_0010_1001_0100};
      BAND_1K_5K: row = '{
        b1: 27'b000_0000_0000_0000_1001_1111_1011, b3: 27'b111_1111_1111_1110_1100_0000_1010,
        b5: 27'b000_0000_0000_0000_1001_1111_1011, a2: 27'b110_0000_0110_1010_0010_0010_0001,
        a3: 27'b011_1110_1100_0111_1111_1011_0100, a4: 27'b110_0001_0011_0001_1011_1100_0100,
        a5: 27'b000_0111_1001_1100_0010_0110_1110};
      BAND_5K_10K: row = '{
        b1: 27'b000_0000_0000_0101_0101_1001_1010, b3: 27'b111_1111_1111_0101_0100_1100_1100,
        b5: 27'b000_0000_0000_0101_0101_1001_1010, a2: 27'b110_0001_0101_0011_1101_0100_0001,
        a3: 27'b011_1100_0011_1101_1011_0101_0010, a4: 27'b110_0011_1000_1011_1100_0110_1010,
        a5: 27'b000_0110_1110_0010_1101_0010_1101};
      BAND_10K_20K: row = '{
        b1: 27'b000_0000_0010_1010_0001_0000_1100, b3: 27'b111_1111_1010_1011_1101_1110_0111,
        b5: 27'b000_0000_0010_1010_0001_0000_1100, a2: 27'b110_0100_1010_0010_1110_1100_1101,
        a3: 27'b010_0100_0001_0110_0011_1101_0001, a4: 27'b110_1010_0011_0110_0001_0001_1100,
        a5: 27'b000_0101_0001_1010_0011_1001_0001};
      BAND_WIDE: row = '{
        b1: 27'b000_0001_0001_0001_1110_0100_1111, b3: 27'b111_1101_1101_1100_0011_0110_0001,
        b5: 27'b000_0001_0001_0001_1110_0100_1111, a2: 27'b111_0001_1100_0100_0100_0111_1000,
        a3: 27'b000_1100_1010_0110_1011_1001_0111, a4: 27'b111_1001_0110_0011_0001_0111_0110,
        a5: 27'b000_0010_0010_0101_0111_1000_1011};
      default: row = '0;
    endcase
  end

  always_ff @(posedge aud_clk) begin
    coefs <= row;
  end

endmodule

`default_nettype wire

// ==== bpf_macros.svh ====
`ifndef BPF_MACROS_SVH
`define BPF_MACROS_SVH

// Audio sample width
`define AUD_W 16

// Filter word, Q4.23
`define COEF_W 27
`define FRAC_W 23

// Level meter output width
`define POWER_W 11

// FIFO depth, also the credits per link
`define FIFO_DEPTH 4

// Envelope follower smoothing shift
`define LPF_SHIFT 6

`endif

// ==== bpf_pkg.sv ====
`default_nettype none
`include "bpf_macros.svh"

package bpf_pkg;

  typedef struct packed {
    logic signed [`AUD_W-1:0] l;
    logic signed [`AUD_W-1:0] r;
  } stereo_sample_t;

  typedef struct packed {
    logic signed [`AUD_W-1:0] l;
    logic signed [`AUD_W-1:0] r;
    logic [`POWER_W-1:0]      power;
  } band_result_t;

  // b2 and b4 are always zero, a1 is always one
  typedef struct packed {
    logic signed [`COEF_W-1:0] b1;
    logic signed [`COEF_W-1:0] b3;
    logic signed [`COEF_W-1:0] b5;
    logic signed [`COEF_W-1:0] a2;
    logic signed [`COEF_W-1:0] a3;
    logic signed [`COEF_W-1:0] a4;
    logic signed [`COEF_W-1:0] a5;
  } coef_set_t;

  typedef enum logic [2:0] {
    BAND_10_100,
    BAND_100_500,
    BAND_500_1K,
    BAND_1K_5K,
    BAND_5K_10K,
    BAND_10K_20K,
    BAND_WIDE
  } band_e;

  typedef enum logic [1:0] {
    F_IDLE,
    F_CALC_L,
    F_CALC_R,
    F_OUT
  } filt_state_e;

endpackage

`default_nettype wire

// ==== envelope_lpf.sv ====
`default_nettype none
`include "bpf_macros.svh"

module envelope_lpf (
  input  logic                    aud_clk,
  input  logic                    reset,
  input  logic                    filt_valid,
  input  bpf_pkg::stereo_sample_t filt_sample,
  input  logic                    filt_enabled,
  output logic                    env_valid,
  output bpf_pkg::band_result_t   env_result
);

  localparam int W_SHIFT = 9;
  localparam int PWR_LSB = 13;

  logic signed [`COEF_W-1:0] w;
  logic signed [`COEF_W-1:0] mag;
  logic signed [`COEF_W-1:0] diff;
  logic signed [`COEF_W-1:0] acc_q;
  logic signed [`COEF_W-1:0] acc_nxt;

  // Left output back in filter word scale
  always_comb begin
    w = {{(`COEF_W-`AUD_W-W_SHIFT){filt_sample.l[`AUD_W-1]}},
         filt_sample.l, {W_SHIFT{1'b0}}};
    mag     = w[`COEF_W-1] ? -w : w;
    diff    = mag - acc_q;
    acc_nxt = acc_q + (diff >>> `LPF_SHIFT);
  end

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      env_valid <= 1'b0;
      acc_q     <= '0;
    end else begin
      env_valid <= filt_valid;
      if (filt_valid && filt_enabled) begin
        acc_q <= acc_nxt;
      end
    end
  end

  always_ff @(posedge aud_clk) begin
    if (filt_valid) begin
      env_result.l     <= filt_sample.l;
      env_result.r     <= filt_sample.r;
      env_result.power <= filt_enabled ? acc_nxt[PWR_LSB +: `POWER_W] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== iir_bandpass.sv ====
`default_nettype none
`include "bpf_macros.svh"

module iir_bandpass (
  input  logic                    aud_clk,
  input  logic                    reset,
  input  logic                    enable,
  input  bpf_pkg::coef_set_t      coefs,
  input  logic                    rx_valid,
  input  bpf_pkg::stereo_sample_t rx_sample,
  output logic                    rx_pop,
  input  logic                    tx_room,
  output logic                    filt_valid,
  output bpf_pkg::stereo_sample_t filt_sample,
  output logic                    filt_enabled
);
  import bpf_pkg::*;

  localparam int X_SHIFT = 8;
  localparam int Y_LSB   = 9;

  filt_state_e               state;
  filt_state_e               state_nxt;
  stereo_sample_t            smp_q;
  logic                      en_q;
  logic                      ch;
  logic                      calc;
  logic signed [`AUD_W-1:0]  x_smp;
  logic signed [`COEF_W-1:0] x;
  logic signed [`COEF_W-1:0] y;
  logic signed [`COEF_W-1:0] z1_q [2];
  logic signed [`COEF_W-1:0] z2_q [2];
  logic signed [`COEF_W-1:0] z3_q [2];
  logic signed [`COEF_W-1:0] z4_q [2];
  logic signed [`COEF_W-1:0] z1_nxt;
  logic signed [`COEF_W-1:0] z2_nxt;
  logic signed [`COEF_W-1:0] z3_nxt;
  logic signed [`COEF_W-1:0] z4_nxt;

  // Full product, scaled back to a filter word
  function automatic logic signed [`COEF_W-1:0] fmul(
    input logic signed [`COEF_W-1:0] a,
    input logic signed [`COEF_W-1:0] b
  );
    logic signed [2*`COEF_W-1:0] p;
    p = a * b;
    return p[`FRAC_W +: `COEF_W];
  endfunction

  assign rx_pop       = (state == F_IDLE) && rx_valid && tx_room;
  assign filt_valid   = (state == F_OUT);
  assign filt_enabled = en_q;

  // Left in F_CALC_L, right in F_CALC_R
  assign ch    = (state == F_CALC_R);
  assign calc  = (state == F_CALC_L) || (state == F_CALC_R);
  assign x_smp = ch ? smp_q.r : smp_q.l;
  assign x     = {{(`COEF_W-`AUD_W-X_SHIFT){x_smp[`AUD_W-1]}}, x_smp, {X_SHIFT{1'b0}}};

  // Transposed direct form II, b2 and b4 terms are zero
  always_comb begin
    y      = fmul(x, coefs.b1) + z1_q[ch];
    z1_nxt = z2_q[ch] - fmul(y, coefs.a2);
    z2_nxt = fmul(x, coefs.b3) + z3_q[ch] - fmul(y, coefs.a3);
    z3_nxt = z4_q[ch] - fmul(y, coefs.a4);
    z4_nxt = fmul(x, coefs.b5) - fmul(y, coefs.a5);
  end

  always_comb begin
    state_nxt = state;
    case (state)
      F_IDLE:   if (rx_pop) state_nxt = F_CALC_L;
      F_CALC_L: state_nxt = F_CALC_R;
      F_CALC_R: state_nxt = F_OUT;
      F_OUT:    state_nxt = F_IDLE;
      default:  state_nxt = F_IDLE;
    endcase
  end

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      state <= F_IDLE;
      en_q  <= 1'b0;
      for (int c = 0; c < 2; c++) begin
        z1_q[c] <= '0;
        z2_q[c] <= '0;
        z3_q[c] <= '0;
        z4_q[c] <= '0;
      end
    end else begin
      state <= state_nxt;
      if (rx_pop) begin
        en_q <= enable;
      end
      // Bypassed samples leave the state words alone
      if (calc && en_q) begin
        z1_q[ch] <= z1_nxt;
        z2_q[ch] <= z2_nxt;
        z3_q[ch] <= z3_nxt;
        z4_q[ch] <= z4_nxt;
      end
    end
  end

  always_ff @(posedge aud_clk) begin
    if (rx_pop) begin
      smp_q <= rx_sample;
    end
    if (state == F_CALC_L) begin
      filt_sample.l <= en_q ? y[Y_LSB +: `AUD_W] : x_smp;
    end
    if (state == F_CALC_R) begin
      filt_sample.r <= en_q ? y[Y_LSB +: `AUD_W] : x_smp;
    end
  end

endmodule

`default_nettype wire

// ==== sample_rx.sv ====
`default_nettype none
`include "bpf_macros.svh"

module sample_rx (
  input  logic                    aud_clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  bpf_pkg::stereo_sample_t in_sample,
  output logic                    in_credit,
  output logic                    rx_valid,
  output bpf_pkg::stereo_sample_t rx_sample,
  input  logic                    rx_pop
);
  import bpf_pkg::*;

  localparam int AW = $clog2(`FIFO_DEPTH);

  stereo_sample_t mem [`FIFO_DEPTH];
  logic [AW:0]    wr_ptr;
  logic [AW:0]    rd_ptr;
  logic           do_pop;

  // Source never sends without a credit, so no full check
  always_ff @(posedge aud_clk) begin
    if (in_valid) begin
      mem[wr_ptr[AW-1:0]] <= in_sample;
    end
  end

  assign rx_valid  = (wr_ptr != rd_ptr);
  assign rx_sample = mem[rd_ptr[AW-1:0]];
  assign do_pop    = rx_pop && rx_valid;

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // One credit back per sample taken by the filter
      in_credit <= do_pop;
    end
  end

endmodule

`default_nettype wire

// ==== sample_tx.sv ====
`default_nettype none
`include "bpf_macros.svh"

module sample_tx (
  input  logic                  aud_clk,
  input  logic                  reset,
  input  logic                  env_valid,
  input  bpf_pkg::band_result_t env_result,
  output logic                  tx_room,
  output logic                  out_valid,
  output bpf_pkg::band_result_t out_result,
  input  logic                  out_credit
);
  import bpf_pkg::*;

  localparam int AW = $clog2(`FIFO_DEPTH);
  localparam int CW = $clog2(`FIFO_DEPTH + 1);

  band_result_t  mem [`FIFO_DEPTH];
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic [AW:0]   count;
  logic [CW-1:0] credits;

  always_ff @(posedge aud_clk) begin
    if (env_valid) begin
      mem[wr_ptr[AW-1:0]] <= env_result;
    end
  end

  assign count      = wr_ptr - rd_ptr;
  // Two free slots, one is kept for the sample in the envelope stage
  assign tx_room    = (count <= (`FIFO_DEPTH - 2));
  assign out_valid  = (count != '0) && (credits != '0);
  assign out_result = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      credits <= CW'(`FIFO_DEPTH);
    end else begin
      if (env_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({out_valid, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire
